// File: oflow_buffer.f
src/oflow_pkg.sv
src/oflow_buffer_regs.sv
src/oflow_fsm_buffer_write.sv
src/oflow_fsm_buffer_read.sv
src/oflow_frame_mem.sv
src/oflow_buffer_top.sv
verification/oflow_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the frame history buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f oflow_buffer.f \
	--top-module oflow_buffer_tb \
	-Mdir obj_dir \
	-o oflow_buffer_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/oflow_buffer_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# verdict comes from the testbench's own summary line
if echo "$sim_out" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: src/oflow_buffer_regs.sv
`timescale 1ns/1ps

module oflow_buffer_regs (
	input  logic                   clk,
	input  logic                   reset_N,
	// config write port
	input  logic                   cfg_we,
	input  oflow_pkg::cfg_addr_t   cfg_addr,
	input  logic [7:0]             cfg_wdata,
	// frame finished, from write fsm
	input  logic                   done_write,
	output oflow_pkg::buffer_cfg_t cfg,
	output oflow_pkg::addr_t       end_pointers [oflow_pkg::NUM_SLOTS]
);

	oflow_pkg::frame_num_t frame_num;
	oflow_pkg::hist_t      num_of_history_frames;

	logic wr_frame_num;	// config write hits index 0
	logic wr_history;
	logic wr_end_ptr;	// config write hits one of the end pointers
	oflow_pkg::cfg_addr_t end_ptr_idx;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------
	assign wr_frame_num = cfg_we && (cfg_addr == oflow_pkg::CFG_IDX_FRAME_NUM);
	assign wr_history   = cfg_we && (cfg_addr == oflow_pkg::CFG_IDX_HISTORY);
	assign wr_end_ptr   = cfg_we && (cfg_addr >= oflow_pkg::CFG_IDX_END_PTR) &&
		(int'(cfg_addr) < int'(oflow_pkg::CFG_IDX_END_PTR) + oflow_pkg::NUM_SLOTS);
	assign end_ptr_idx  = cfg_addr - oflow_pkg::CFG_IDX_END_PTR;	// slot number

	// ------------------------------------------------------------------------
	// frame counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			frame_num <= '0;
		end else if (wr_frame_num) begin
			frame_num <= oflow_pkg::frame_num_t'(cfg_wdata);	// cpu wins over increment
		end else if (done_write) begin
			frame_num <= frame_num + 8'd1;	// wraps at 255
		end
	end

	// history depth, never 0 after reset
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			num_of_history_frames <= 3'd1;
		end else if (wr_history) begin
			num_of_history_frames <= oflow_pkg::hist_t'(cfg_wdata);
		end
	end

	// one end pointer per slot
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < oflow_pkg::NUM_SLOTS; i++) begin
				end_pointers[i] <= '0;
			end
		end else if (wr_end_ptr) begin
			end_pointers[end_ptr_idx] <= oflow_pkg::addr_t'(cfg_wdata);
		end
	end

	// ------------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------------
	assign cfg.frame_num             = frame_num;
	assign cfg.num_of_history_frames = num_of_history_frames;
	assign cfg.write_slot            =	// ring position of the current frame
		oflow_pkg::slot_t'(frame_num % num_of_history_frames);

	// a bad history count would send frames outside the ring
	a_history_range : assert property (@(posedge clk) disable iff (!reset_N)
		(num_of_history_frames >= 3'd1) &&
		(int'(num_of_history_frames) <= oflow_pkg::NUM_SLOTS))
		else $error("history count %0d out of range", num_of_history_frames);

endmodule

// File: src/oflow_buffer_top.sv
`timescale 1ns/1ps

module oflow_buffer_top #(
	parameter int SLOT_DEPTH = 64
) (
	input  logic                   clk,
	input  logic                   reset_N,
	// config port
	input  logic                   cfg_we,
	input  oflow_pkg::cfg_addr_t   cfg_addr,
	input  logic [7:0]             cfg_wdata,
	// write side, from core
	input  logic                   start_write,
	input  logic                   ready_from_core,
	input  oflow_pkg::pixel_pair_t wr_pair,
	output logic                   done_write,
	output logic                   wr_strobe,	// pair taken this cycle
	// read side
	input  logic                   start_read,
	input  oflow_pkg::hist_t       frames_back,
	output oflow_pkg::pixel_pair_t rd_pair,
	output logic                   rd_valid,
	output logic                   done_read
);

	// ------------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------------
	oflow_pkg::buffer_cfg_t cfg;
	oflow_pkg::addr_t       end_pointers [oflow_pkg::NUM_SLOTS];
	oflow_pkg::offset_t     offset_0;
	oflow_pkg::offset_t     offset_1;
	logic                   rd_en;
	oflow_pkg::slot_t       rd_slot;
	oflow_pkg::offset_t     rd_offset;

	// frame counter, history depth, end pointers
	oflow_buffer_regs i_regs (
		.clk          (clk),
		.reset_N      (reset_N),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.done_write   (done_write),	// advances frame_num
		.cfg          (cfg),
		.end_pointers (end_pointers)
	);

	oflow_fsm_buffer_write #(.SLOT_DEPTH(SLOT_DEPTH)) i_fsm_write (
		.clk             (clk),
		.reset_N         (reset_N),
		.cfg             (cfg),
		.end_pointers    (end_pointers),
		.start_write     (start_write),
		.ready_from_core (ready_from_core),
		.done_write      (done_write),
		.we              (wr_strobe),	// doubles as the core's strobe
		.offset_0        (offset_0),
		.offset_1        (offset_1)
	);

	oflow_fsm_buffer_read #(.SLOT_DEPTH(SLOT_DEPTH)) i_fsm_read (
		.clk          (clk),
		.reset_N      (reset_N),
		.cfg          (cfg),
		.end_pointers (end_pointers),
		.start_read   (start_read),
		.frames_back  (frames_back),
		.rd_en        (rd_en),
		.rd_slot      (rd_slot),
		.rd_offset    (rd_offset),
		.rd_valid     (rd_valid),
		.done_read    (done_read)
	);

	// write data straight from the core
	oflow_frame_mem #(.SLOT_DEPTH(SLOT_DEPTH)) i_mem (
		.clk       (clk),
		.we        (wr_strobe),
		.wr_slot   (cfg.write_slot),
		.offset_0  (offset_0),
		.offset_1  (offset_1),
		.wr_pair   (wr_pair),
		.rd_en     (rd_en),
		.rd_slot   (rd_slot),
		.rd_offset (rd_offset),
		.rd_pair   (rd_pair)
	);

endmodule

// File: src/oflow_frame_mem.sv
`timescale 1ns/1ps

module oflow_frame_mem #(
	parameter int SLOT_DEPTH = 64
) (
	input  logic                   clk,
	// write side, two words per cycle
	input  logic                   we,
	input  oflow_pkg::slot_t       wr_slot,
	input  oflow_pkg::offset_t     offset_0,
	input  oflow_pkg::offset_t     offset_1,
	input  oflow_pkg::pixel_pair_t wr_pair,
	// read side, pair lands one cycle after rd_en
	input  logic                   rd_en,
	input  oflow_pkg::slot_t       rd_slot,
	input  oflow_pkg::offset_t     rd_offset,
	output oflow_pkg::pixel_pair_t rd_pair
);

	// ------------------------------------------------------------------------
	// storage, one row per slot
	// ------------------------------------------------------------------------
	oflow_pkg::pixel_t mem [oflow_pkg::NUM_SLOTS][SLOT_DEPTH];

	oflow_pkg::offset_t rd_offset_1;	// odd word of the read pair

	assign rd_offset_1 = rd_offset + 6'd1;

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_slot][offset_0] <= wr_pair.word_0;
			mem[wr_slot][offset_1] <= wr_pair.word_1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_pair.word_0 <= mem[rd_slot][rd_offset];
			rd_pair.word_1 <= mem[rd_slot][rd_offset_1];	// holds when idle
		end
	end

	// the write fsm must hand over an adjacent pair inside the slot
	a_wr_in_slot : assert property (@(posedge clk)
		we |-> (int'(offset_1) < SLOT_DEPTH) && (offset_1 == offset_0 + 6'd1))
		else $error("pair write at %0d/%0d outside slot", offset_0, offset_1);

endmodule

// File: src/oflow_fsm_buffer_read.sv
`timescale 1ns/1ps

module oflow_fsm_buffer_read #(
	parameter int SLOT_DEPTH = 64
) (
	input  logic                   clk,
	input  logic                   reset_N,
	input  oflow_pkg::buffer_cfg_t cfg,
	input  oflow_pkg::addr_t       end_pointers [oflow_pkg::NUM_SLOTS],
	input  logic                   start_read,	// pulse
	input  oflow_pkg::hist_t       frames_back,	// 0 is the last finished frame
	output logic                   rd_en,
	output oflow_pkg::slot_t       rd_slot,
	output oflow_pkg::offset_t     rd_offset,
	output logic                   rd_valid,	// rd_pair valid, one after issue
	output logic                   done_read	// with the last rd_valid
);

	localparam int EW = $bits(oflow_pkg::addr_t) + 1;

	typedef enum logic {
		idle_st,
		stream_st
	} rd_state_t;

	rd_state_t             current_state;
	rd_state_t             next_state;
	oflow_pkg::frame_num_t target_frame;	// serial number to replay
	oflow_pkg::slot_t      slot_q;
	oflow_pkg::offset_t    counter_offset;
	logic [EW-1:0]         end_lim;
	logic                  last_pair;

	// ------------------------------------------------------------------------
	// slot select
	// ------------------------------------------------------------------------
	// 8 bit wrap, same as the write side saw the frame number
	assign target_frame = cfg.frame_num - 8'd1 - oflow_pkg::frame_num_t'(frames_back);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			slot_q <= '0;
		else if (current_state == idle_st && start_read)
			slot_q <= oflow_pkg::slot_t'(target_frame % cfg.num_of_history_frames);
	end

	// clamp like the write fsm
	always_comb begin
		if (int'(end_pointers[slot_q]) > SLOT_DEPTH)
			end_lim = EW'(SLOT_DEPTH);
		else
			end_lim = {1'b0, end_pointers[slot_q]};
	end

	assign last_pair = ({1'b0, counter_offset} + EW'(2)) >= end_lim;

	// ------------------------------------------------------------------------
	// stream fsm
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			current_state <= idle_st;
		else
			current_state <= next_state;
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			idle_st:   if (start_read) next_state = stream_st;
			stream_st: if (last_pair) next_state = idle_st;	// no back-pressure
			default:   next_state = idle_st;
		endcase
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			counter_offset <= '0;
		else if (current_state == idle_st)
			counter_offset <= '0;
		else
			counter_offset <= counter_offset + 6'd2;	// one pair per cycle
	end

	assign rd_en     = (current_state == stream_st);
	assign rd_slot   = slot_q;
	assign rd_offset = counter_offset;

	// match the registered memory read
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			rd_valid  <= 1'b0;
			done_read <= 1'b0;
		end else begin
			rd_valid  <= rd_en;
			done_read <= rd_en && last_pair;
		end
	end

	// asking past the history depth would alias a newer frame
	a_frames_back : assert property (@(posedge clk) disable iff (!reset_N)
		(current_state == idle_st && start_read) |->
			(frames_back < cfg.num_of_history_frames))
		else $error("frames_back %0d beyond history", frames_back);

endmodule

// File: src/oflow_fsm_buffer_write.sv
`timescale 1ns/1ps

module oflow_fsm_buffer_write #(
	parameter int SLOT_DEPTH = 64
) (
	input  logic                   clk,
	input  logic                   reset_N,
	input  oflow_pkg::buffer_cfg_t cfg,
	input  oflow_pkg::addr_t       end_pointers [oflow_pkg::NUM_SLOTS],
	input  logic                   start_write,	// pulse from core fsm
	input  logic                   ready_from_core,	// level, core takes next pair
	output logic                   done_write,	// with the last strobe
	output logic                   we,
	output oflow_pkg::offset_t     offset_0,
	output oflow_pkg::offset_t     offset_1
);

	localparam int EW = $bits(oflow_pkg::addr_t) + 1;	// room for counter + 2

	typedef enum logic [1:0] {
		idle_st,
		offset_st,
		wait_st
	} wr_state_t;

	wr_state_t          current_state;
	wr_state_t          next_state;
	oflow_pkg::offset_t counter_offset;	// even offset of the pair in flight
	logic [EW-1:0]      end_lim;	// end pointer clamped to slot size
	logic               last_pair;

	// ------------------------------------------------------------------------
	// end of frame
	// ------------------------------------------------------------------------
	always_comb begin
		if (int'(end_pointers[cfg.write_slot]) > SLOT_DEPTH)
			end_lim = EW'(SLOT_DEPTH);
		else
			end_lim = {1'b0, end_pointers[cfg.write_slot]};
	end

	// pair covers the last word below end, ceil(end/2) pairs, min one
	assign last_pair = ({1'b0, counter_offset} + EW'(2)) >= end_lim;

	// ------------------------------------------------------------------------
	// state and counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			current_state <= idle_st;
		else
			current_state <= next_state;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			counter_offset <= '0;
		end else if (current_state == idle_st) begin
			counter_offset <= '0;	// every frame from offset 0
		end else if (next_state == offset_st) begin
			counter_offset <= counter_offset + 6'd2;	// stay or back from wait
		end
	end

	always_comb begin
		next_state = current_state;
		done_write = 1'b0;
		case (current_state)
			idle_st: begin
				if (start_write)
					next_state = offset_st;
			end
			offset_st: begin
				if (last_pair) begin
					next_state = idle_st;
					done_write = 1'b1;
				end else if (!ready_from_core) begin
					next_state = wait_st;	// core stalls us
				end
			end
			wait_st: begin
				if (ready_from_core)
					next_state = offset_st;
			end
			default: next_state = idle_st;
		endcase
	end

	assign we       = (current_state == offset_st);	// one pair per offset cycle
	assign offset_0 = counter_offset;
	assign offset_1 = counter_offset + 6'd1;

	// slot and end of frame hold still while a frame is in flight
	a_cfg_stable : assert property (@(posedge clk) disable iff (!reset_N)
		(current_state != idle_st && $past(current_state != idle_st)) |->
			($stable(cfg.write_slot) && $stable(end_lim)))
		else $error("write slot or end pointer changed during a frame");

endmodule

// File: src/oflow_pkg.sv
package oflow_pkg;

	// ------------------------------------------------------------------------
	// ring geometry
	// ------------------------------------------------------------------------
	localparam int NUM_SLOTS = 5;	// frame slots held in the history ring

	typedef logic [5:0] addr_t;	// word address inside one slot
	typedef logic [5:0] offset_t;	// word-pair offset inside one slot
	typedef logic [2:0] slot_t;	// slot index 0..NUM_SLOTS-1
	typedef logic [7:0] frame_num_t;	// serial number, wraps 255 -> 0
	typedef logic [2:0] hist_t;	// history frames in use, 1..NUM_SLOTS
	typedef logic [7:0] pixel_t;	// one stored word

	// two words moved per cycle
	typedef struct packed {
		pixel_t word_1;	// odd offset
		pixel_t word_0;	// even offset
	} pixel_pair_t;

	// ------------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------------
	typedef logic [2:0] cfg_addr_t;

	localparam cfg_addr_t CFG_IDX_FRAME_NUM = 3'd0;
	localparam cfg_addr_t CFG_IDX_HISTORY   = 3'd1;
	localparam cfg_addr_t CFG_IDX_END_PTR   = 3'd2;	// slots 0..4 at 2..6

	// regs -> both controllers
	typedef struct packed {
		frame_num_t frame_num;	// frame being written now
		hist_t      num_of_history_frames;
		slot_t      write_slot;	// frame_num mod history
	} buffer_cfg_t;

endpackage

// File: verification/oflow_buffer_tb.sv
`timescale 1ns/1ps

module oflow_buffer_tb;

	localparam int SLOT_DEPTH     = 64;
	localparam int TIMEOUT_CYCLES = 4000;	// ~15 frames, worst 32 pairs each, stalls

	logic                   clk;
	logic                   reset_N;
	logic                   cfg_we;
	oflow_pkg::cfg_addr_t   cfg_addr;
	logic [7:0]             cfg_wdata;
	logic                   start_write;
	logic                   ready_from_core;
	oflow_pkg::pixel_pair_t wr_pair;
	logic                   done_write;
	logic                   wr_strobe;
	logic                   start_read;
	oflow_pkg::hist_t       frames_back;
	oflow_pkg::pixel_pair_t rd_pair;
	logic                   rd_valid;
	logic                   done_read;

	// reference copy of the ring and its registers
	oflow_pkg::pixel_t     model_mem [oflow_pkg::NUM_SLOTS][SLOT_DEPTH];
	oflow_pkg::frame_num_t model_frame;
	oflow_pkg::hist_t      model_hist;
	oflow_pkg::addr_t      model_end [oflow_pkg::NUM_SLOTS];

	integer seed = 29457;
	int     cycles = 0;
	int     errors = 0;
	int     errors_at_start;
	int     tests_run = 0;
	int     tests_failed = 0;
	string  current_test;

	oflow_buffer_top #(.SLOT_DEPTH(SLOT_DEPTH)) i_oflow_buffer_top (
		.clk             (clk),
		.reset_N         (reset_N),
		.cfg_we          (cfg_we),
		.cfg_addr        (cfg_addr),
		.cfg_wdata       (cfg_wdata),
		.start_write     (start_write),
		.ready_from_core (ready_from_core),
		.wr_pair         (wr_pair),
		.done_write      (done_write),
		.wr_strobe       (wr_strobe),
		.start_read      (start_read),
		.frames_back     (frames_back),
		.rd_pair         (rd_pair),
		.rd_valid        (rd_valid),
		.done_read       (done_read)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;	// 40 ns period

	// hang guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------
	function automatic int pair_count(input oflow_pkg::addr_t end_ptr);
		int n;
		n = (int'(end_ptr) + 1) / 2;	// ceil(end/2)
		if (n < 1)
			n = 1;	// empty frame still moves one pair
		return n;
	endfunction

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("ERROR %s: %s expected %0h actual %0h", current_test, what, exp, act);
		errors++;
	endtask

	task automatic complain(input string what);
		$display("%s: %s", current_test, what);
		errors++;
	endtask

	task automatic begin_test(input string name);
		current_test    = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			$display("test %s: passed", current_test);
		end else begin
			$display("test %s: failed with %0d errors", current_test, errors - errors_at_start);
			tests_failed++;
		end
	endtask

	// inputs change 2 ns after the edge
	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic cfg_write(input int addr, input logic [7:0] data);
		cfg_we    = 1'b1;
		cfg_addr  = oflow_pkg::cfg_addr_t'(addr);
		cfg_wdata = data;
		step_cycle();
		cfg_we = 1'b0;
		if (addr == 0)
			model_frame = data;
		else if (addr == 1)
			model_hist = oflow_pkg::hist_t'(data);
		else
			model_end[addr - 2] = oflow_pkg::addr_t'(data);	// index 2..6 is slot 0..4
	endtask

	// --------------------------------------------------------------------------
	// core side of a frame write
	// --------------------------------------------------------------------------
	task automatic write_frame(input bit stall);
		int slot;
		int n;
		int cnt;
		int cyc;
		bit done;
		bit took;
		bit prev_ready;
		slot = int'(model_frame) % int'(model_hist);
		n    = pair_count(model_end[slot]);
		cnt  = 0;
		done = 1'b0;
		wr_pair         = 16'($random(seed));
		ready_from_core = 1'b1;
		prev_ready      = 1'b1;
		start_write     = 1'b1;
		step_cycle();
		start_write = 1'b0;
		cyc = 1;
		while (!done) begin
			@(negedge clk);
			took = wr_strobe;
			if (wr_strobe) begin
				if (cnt == 0 && cyc != 1)
					mismatch("first strobe cycle", 1, 32'(cyc));
				if (!prev_ready)
					complain("write strobe in the cycle after ready was low");
				model_mem[slot][2*cnt]     = wr_pair.word_0;	// taken at the next edge
				model_mem[slot][2*cnt + 1] = wr_pair.word_1;
				cnt++;
			end
			if (done_write) begin
				if (!wr_strobe)
					complain("done_write without a write strobe");
				done = 1'b1;
			end
			prev_ready = ready_from_core;
			step_cycle();
			cyc++;
			if (took)
				wr_pair = 16'($random(seed));	// next pair once this one is taken
			if (stall)
				ready_from_core = 1'($random(seed));
		end
		ready_from_core = 1'b1;
		if (cnt != n)
			mismatch("strobe count", 32'(n), 32'(cnt));
		model_frame = model_frame + 8'd1;
	endtask

	// end pointer of the slot about to be written, then the frame
	task automatic write_with_end(input int end_ptr, input bit stall);
		int slot;
		slot = int'(model_frame) % int'(model_hist);
		cfg_write(2 + slot, 8'(end_ptr));
		write_frame(stall);
	endtask

	task automatic read_frame(input int fb);
		oflow_pkg::frame_num_t target;
		int slot;
		int n;
		int cnt;
		int cyc;
		bit done;
		target = model_frame - 8'd1 - 8'(fb);	// newest finished frame back by fb
		slot   = int'(target) % int'(model_hist);
		n      = pair_count(model_end[slot]);
		cnt    = 0;
		done   = 1'b0;
		frames_back = oflow_pkg::hist_t'(fb);
		start_read  = 1'b1;
		step_cycle();
		start_read = 1'b0;
		cyc = 1;
		while (!done) begin
			@(negedge clk);
			if (rd_valid) begin
				if (cnt == 0 && cyc != 2)
					mismatch("first rd_valid cycle", 2, 32'(cyc));
				if (rd_pair.word_0 !== model_mem[slot][2*cnt])
					mismatch($sformatf("word at offset %0d", 2*cnt),
						32'(model_mem[slot][2*cnt]), 32'(rd_pair.word_0));
				if (rd_pair.word_1 !== model_mem[slot][2*cnt + 1])
					mismatch($sformatf("word at offset %0d", 2*cnt + 1),
						32'(model_mem[slot][2*cnt + 1]), 32'(rd_pair.word_1));
				cnt++;
			end else if (cnt > 0) begin
				complain("rd_valid dropped before done_read");
			end
			if (done_read) begin
				if (!rd_valid)
					complain("done_read without rd_valid");
				done = 1'b1;
			end
			step_cycle();
			cyc++;
		end
		if (cnt != n)
			mismatch("read pair count", 32'(n), 32'(cnt));
	endtask

	// --------------------------------------------------------------------------
	// directed tests
	// --------------------------------------------------------------------------
	task automatic test_reset();
		begin_test("reset");
		repeat (4) begin
			@(negedge clk);
			if (wr_strobe || done_write || rd_valid || done_read)
				complain("output flag high while idle after reset");
			step_cycle();
		end
		cfg_write(1, 8'd1);
		write_frame(1'b0);	// end pointer still 0 from reset, one pair
		read_frame(0);
		end_test();
	endtask

	task automatic test_basic();
		begin_test("basic");
		cfg_write(1, 8'd1);
		write_with_end(10, 1'b0);	// 5 pairs
		read_frame(0);
		end_test();
	endtask

	task automatic test_odd_end();
		begin_test("odd_end");
		write_with_end(7, 1'b0);	// offsets 0..6, 4 pairs
		read_frame(0);
		end_test();
	endtask

	task automatic test_backpressure();
		begin_test("backpressure");
		write_with_end(23, 1'b1);
		read_frame(0);
		end_test();
	endtask

	task automatic test_ring();
		begin_test("ring");
		cfg_write(0, 8'd0);
		cfg_write(1, 8'd3);
		write_with_end(12, 1'b0);
		write_with_end(9, 1'b0);
		write_with_end(16, 1'b0);
		write_with_end(5, 1'b0);	// frame 3 lands on slot 0 again
		for (int fb = 0; fb < 3; fb++)
			read_frame(fb);
		end_test();
	endtask

	task automatic test_wrap();
		begin_test("wrap");
		cfg_write(0, 8'd254);
		cfg_write(1, 8'd4);
		write_with_end(6, 1'b0);
		write_with_end(11, 1'b0);
		write_with_end(3, 1'b0);	// counter ends at 1
		for (int fb = 0; fb < 3; fb++)
			read_frame(fb);
		end_test();
	endtask

	initial begin
		reset_N         = 1'b0;
		cfg_we          = 1'b0;
		cfg_addr        = '0;
		cfg_wdata       = '0;
		start_write     = 1'b0;
		ready_from_core = 1'b1;
		wr_pair         = '0;
		start_read      = 1'b0;
		frames_back     = '0;
		model_frame     = '0;	// register values after reset
		model_hist      = 3'd1;
		for (int i = 0; i < oflow_pkg::NUM_SLOTS; i++)
			model_end[i] = '0;
		repeat (8) @(posedge clk);
		#2;
		reset_N = 1'b1;

		test_reset();
		test_basic();
		test_odd_end();
		test_backpressure();
		test_ring();
		test_wrap();

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
